// File: include/core_defs.svh
// MIPS32 opcode and funct encodings for the supported subset only, and the core starts fetching at address zero
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// fetch
`define PC_INIT 32'h0000_0000
`define PC_INCR 32'd4

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LB      6'h20
`define OP_LH      6'h21
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_LHU     6'h25
`define OP_SW      6'h2b

// funct codes under OP_SPECIAL
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2a
`define FN_SLTU 6'h2b

`endif

// File: source/core.sv
// both memories must answer combinationally in the same cycle, and stores are word only
`timescale 1ns/1ps

module core import core_pkg::*; (
  input  logic  CLK,
  input  logic  reset,
  input  word_t instr,
  input  word_t readData,
  output word_t pc,
  output word_t aluOut,
  output word_t writeData,
  output logic  memRead,
  output logic  memWrite
);

  ctrl_t   ctrl;
  regIdx_t rs;
  regIdx_t rt;
  word_t   readData1;
  word_t   readData2;
  word_t   aluResult;
  word_t   nextPc;
  wb_t     wb;

  programCounter pcReg (
    .CLK    (CLK),
    .reset  (reset),
    .nextPc (nextPc),
    .pc     (pc)
  );

  instrDecoder decode (
    .instr (instr),
    .ctrl  (ctrl),
    .rs    (rs),
    .rt    (rt)
  );

  registerFile regFile (
    .CLK       (CLK),
    .reset     (reset),
    .rs        (rs),
    .rt        (rt),
    .wb        (wb),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  executeUnit execute (
    .ctrl      (ctrl),
    .pc        (pc),
    .readData1 (readData1),
    .readData2 (readData2),
    .aluResult (aluResult),
    .nextPc    (nextPc)
  );

  // load data comes back in the same cycle
  resultSelect result (
    .ctrl      (ctrl),
    .pc        (pc),
    .aluResult (aluResult),
    .readData  (readData),
    .wb        (wb)
  );

  // data memory side
  assign aluOut    = aluResult;
  assign writeData = readData2;
  assign memRead   = ctrl.memRead;
  assign memWrite  = ctrl.memWrite;

endmodule

// File: source/core_pkg.sv
// types for a fixed 32-bit core, and the code values here are private to decode, execute and result
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [3:0]  aluOp_t;
  typedef logic [1:0]  pcSel_t;
  typedef logic [2:0]  brKind_t;
  typedef logic [1:0]  memSize_t;

  // alu operations
  localparam aluOp_t aluAdd  = 4'd0;
  localparam aluOp_t aluSub  = 4'd1;
  localparam aluOp_t aluAnd  = 4'd2;
  localparam aluOp_t aluOr   = 4'd3;
  localparam aluOp_t aluXor  = 4'd4;
  localparam aluOp_t aluNor  = 4'd5;
  localparam aluOp_t aluSlt  = 4'd6;
  localparam aluOp_t aluSltu = 4'd7;
  localparam aluOp_t aluSll  = 4'd8;
  localparam aluOp_t aluSrl  = 4'd9;
  localparam aluOp_t aluSra  = 4'd10;
  localparam aluOp_t aluLui  = 4'd11;

  // next pc sources
  localparam pcSel_t pcSelNext   = 2'd0;
  localparam pcSel_t pcSelJump   = 2'd1;
  localparam pcSel_t pcSelBranch = 2'd2;
  localparam pcSel_t pcSelReg    = 2'd3;

  // branch conditions
  localparam brKind_t brNone = 3'd0;
  localparam brKind_t brEq   = 3'd1;
  localparam brKind_t brNe   = 3'd2;
  localparam brKind_t brLez  = 3'd3;
  localparam brKind_t brGtz  = 3'd4;

  // load and store widths
  localparam memSize_t memWord = 2'd0;
  localparam memSize_t memHalf = 2'd1;
  localparam memSize_t memByte = 2'd2;

  typedef struct packed {
    aluOp_t      aluOp;
    logic        aluSrcImm;
    logic        signExtend;
    logic [4:0]  shamt;
    word_t       immediate;
    brKind_t     branch;
    pcSel_t      pcSel;
    logic [25:0] jumpTarget;
    logic        link;
    logic        memRead;
    logic        memWrite;
    memSize_t    memSize;
    logic        memSigned;
    logic        regWrite;
    regIdx_t     dest;
  } ctrl_t;

  typedef struct packed {
    logic    en;
    regIdx_t dest;
    word_t   value;
  } wb_t;

endpackage

// File: source/executeUnit.sv
// no delay slot, so branch and jump targets are taken in the same cycle and computed from pc plus 4
`timescale 1ns/1ps
`include "core_defs.svh"

module executeUnit import core_pkg::*; (
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t readData1,
  input  word_t readData2,
  output word_t aluResult,
  output word_t nextPc
);

  word_t extImm;
  word_t operandB;
  word_t pcPlus4;
  word_t branchTarget;
  word_t jumpAddr;
  logic  taken;

  assign extImm = ctrl.signExtend ? {{16{ctrl.immediate[15]}}, ctrl.immediate[15:0]}
                                  : {16'h0000, ctrl.immediate[15:0]};
  assign operandB = ctrl.aluSrcImm ? extImm : readData2;

  // alu
  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  aluResult = readData1 + operandB;
      aluSub:  aluResult = readData1 - operandB;
      aluAnd:  aluResult = readData1 & operandB;
      aluOr:   aluResult = readData1 | operandB;
      aluXor:  aluResult = readData1 ^ operandB;
      aluNor:  aluResult = ~(readData1 | operandB);
      aluSlt:  aluResult = {31'b0, $signed(readData1) < $signed(operandB)};
      aluSltu: aluResult = {31'b0, readData1 < operandB};
      // shifts act on rt by the shamt field
      aluSll:  aluResult = operandB << ctrl.shamt;
      aluSrl:  aluResult = operandB >> ctrl.shamt;
      aluSra:  aluResult = word_t'($signed(operandB) >>> ctrl.shamt);
      aluLui:  aluResult = {operandB[15:0], 16'h0000};
      default: aluResult = '0;
    endcase
  end

  // branch comparator
  always_comb begin
    case (ctrl.branch)
      brEq:    taken = (readData1 == readData2);
      brNe:    taken = (readData1 != readData2);
      brLez:   taken = readData1[31] || (readData1 == '0);
      brGtz:   taken = !readData1[31] && (readData1 != '0);
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4      = pc + `PC_INCR;
  assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
  assign jumpAddr     = {pcPlus4[31:28], ctrl.jumpTarget, 2'b00};

  always_comb begin
    case (ctrl.pcSel)
      pcSelJump:   nextPc = jumpAddr;
      pcSelBranch: nextPc = taken ? branchTarget : pcPlus4;
      pcSelReg:    nextPc = readData1;
      default:     nextPc = pcPlus4;
    endcase
  end

endmodule

// File: source/instrDecoder.sv
// unknown opcodes and funct codes decode as a no-op with every write disabled
`timescale 1ns/1ps
`include "core_defs.svh"

module instrDecoder import core_pkg::*; (
  input  word_t   instr,
  output ctrl_t   ctrl,
  output regIdx_t rs,
  output regIdx_t rt
);

  logic [5:0] opcode;
  logic [5:0] funct;
  regIdx_t    rd;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  always_comb begin
    ctrl            = '0;
    ctrl.shamt      = instr[10:6];
    // raw field, extension happens in execute
    ctrl.immediate  = {16'h0000, instr[15:0]};
    ctrl.jumpTarget = instr[25:0];
    ctrl.pcSel      = pcSelNext;
    ctrl.branch     = brNone;
    ctrl.memSize    = memWord;
    ctrl.aluOp      = aluAdd;
    ctrl.dest       = rt;

    case (opcode)
      `OP_SPECIAL: begin
        ctrl.dest     = rd;
        ctrl.regWrite = 1'b1;
        case (funct)
          `FN_ADDU: ctrl.aluOp = aluAdd;
          `FN_SUBU: ctrl.aluOp = aluSub;
          `FN_AND:  ctrl.aluOp = aluAnd;
          `FN_OR:   ctrl.aluOp = aluOr;
          `FN_XOR:  ctrl.aluOp = aluXor;
          `FN_NOR:  ctrl.aluOp = aluNor;
          `FN_SLT:  ctrl.aluOp = aluSlt;
          `FN_SLTU: ctrl.aluOp = aluSltu;
          `FN_SLL:  ctrl.aluOp = aluSll;
          `FN_SRL:  ctrl.aluOp = aluSrl;
          `FN_SRA:  ctrl.aluOp = aluSra;
          `FN_JR: begin
            ctrl.regWrite = 1'b0;
            ctrl.pcSel    = pcSelReg;
          end
          default: ctrl.regWrite = 1'b0;
        endcase
      end

      // immediate alu forms write rt
      `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
        ctrl.aluSrcImm  = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.signExtend = (opcode == `OP_ADDIU) || (opcode == `OP_SLTI);
        case (opcode)
          `OP_SLTI: ctrl.aluOp = aluSlt;
          `OP_ANDI: ctrl.aluOp = aluAnd;
          `OP_ORI:  ctrl.aluOp = aluOr;
          `OP_XORI: ctrl.aluOp = aluXor;
          `OP_LUI:  ctrl.aluOp = aluLui;
          default:  ctrl.aluOp = aluAdd;
        endcase
      end

      `OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU: begin
        ctrl.aluSrcImm  = 1'b1;
        ctrl.signExtend = 1'b1;
        ctrl.memRead    = 1'b1;
        ctrl.regWrite   = 1'b1;
        ctrl.memSigned  = (opcode == `OP_LH) || (opcode == `OP_LB);
        if (opcode == `OP_LH || opcode == `OP_LHU) begin
          ctrl.memSize = memHalf;
        end else if (opcode == `OP_LB || opcode == `OP_LBU) begin
          ctrl.memSize = memByte;
        end
      end

      `OP_SW: begin
        ctrl.aluSrcImm  = 1'b1;
        ctrl.signExtend = 1'b1;
        ctrl.memWrite   = 1'b1;
      end

      // branch offset is always signed
      `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
        ctrl.signExtend = 1'b1;
        ctrl.pcSel      = pcSelBranch;
        case (opcode)
          `OP_BEQ:  ctrl.branch = brEq;
          `OP_BNE:  ctrl.branch = brNe;
          `OP_BLEZ: ctrl.branch = brLez;
          default:  ctrl.branch = brGtz;
        endcase
      end

      `OP_J: ctrl.pcSel = pcSelJump;

      `OP_JAL: begin
        ctrl.pcSel    = pcSelJump;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.dest     = 5'd31;
      end

      default: ctrl.regWrite = 1'b0;
    endcase
  end

endmodule

// File: source/programCounter.sv
// the PC loads the reset address on a synchronous reset and the next PC on every other clock
`timescale 1ns/1ps
`include "core_defs.svh"

module programCounter import core_pkg::*; (
  input  logic  CLK,
  input  logic  reset,
  input  word_t nextPc,
  output word_t pc
);

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc <= `PC_INIT;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// File: source/registerFile.sv
// two asynchronous read ports and one write port, and register zero always reads zero
`timescale 1ns/1ps

module registerFile import core_pkg::*; (
  input  logic    CLK,
  input  logic    reset,
  input  regIdx_t rs,
  input  regIdx_t rt,
  input  wb_t     wb,
  output word_t   readData1,
  output word_t   readData2
);

  word_t regs [32];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.dest != '0) begin
      // r0 stays at its reset value
      regs[wb.dest] <= wb.value;
    end
  end

  assign readData1 = regs[rs];
  assign readData2 = regs[rt];

endmodule

// File: source/resultSelect.sv
// big-endian byte lanes, and misaligned half and word loads are not detected
`timescale 1ns/1ps
`include "core_defs.svh"

module resultSelect import core_pkg::*; (
  input  ctrl_t ctrl,
  input  word_t pc,
  input  word_t aluResult,
  input  word_t readData,
  output wb_t   wb
);

  logic [7:0]  loadByte;
  logic [15:0] loadHalf;
  word_t       loadValue;
  word_t       linkAddr;

  // byte 0 sits in the top lane
  always_comb begin
    case (aluResult[1:0])
      2'd0:    loadByte = readData[31:24];
      2'd1:    loadByte = readData[23:16];
      2'd2:    loadByte = readData[15:8];
      default: loadByte = readData[7:0];
    endcase
  end

  assign loadHalf = aluResult[1] ? readData[15:0] : readData[31:16];

  always_comb begin
    case (ctrl.memSize)
      memByte: loadValue = ctrl.memSigned ? {{24{loadByte[7]}}, loadByte}
                                          : {24'h000000, loadByte};
      memHalf: loadValue = ctrl.memSigned ? {{16{loadHalf[15]}}, loadHalf}
                                          : {16'h0000, loadHalf};
      default: loadValue = readData;
    endcase
  end

  // return address skips only the jal itself
  assign linkAddr = pc + `PC_INCR;

  always_comb begin
    wb.en   = ctrl.regWrite;
    wb.dest = ctrl.dest;
    if (ctrl.memRead) begin
      wb.value = loadValue;
    end else if (ctrl.link) begin
      wb.value = linkAddr;
    end else begin
      wb.value = aluResult;
    end
  end

endmodule

// File: tb.f
+incdir+include
source/core_pkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/resultSelect.sv
source/programCounter.sv
source/core.sv
testbench/tbMemory.sv
testbench/coreTb.sv

// File: testbench/coreTb.sv
// random program for the single-cycle core, and all data accesses stay inside a 1 KB RAM
`timescale 1ns/1ps
`include "core_defs.svh"

module coreTb import core_pkg::*; ();

  logic  CLK;
  logic  reset;
  word_t pc;
  word_t instr;
  word_t readData;
  word_t aluOut;
  word_t writeData;
  logic  memRead;
  logic  memWrite;

  integer seed;
  int     progLen;
  logic   loaded;
  logic   done;
  logic [15:0] slot;
  word_t  prog [1024];

  // architectural model state
  word_t  modelRegs [32];
  word_t  modelMem [256];
  word_t  modelPc;
  logic   expStore;
  logic   expLoad;
  word_t  expAddr;
  word_t  expData;

  core u_dut (
    .CLK       (CLK),
    .reset     (reset),
    .instr     (instr),
    .readData  (readData),
    .pc        (pc),
    .aluOut    (aluOut),
    .writeData (writeData),
    .memRead   (memRead),
    .memWrite  (memWrite)
  );

  tbMemory u_mem (
    .CLK       (CLK),
    .pc        (pc),
    .instr     (instr),
    .addr      (aluOut),
    .writeData (writeData),
    .memWrite  (memWrite),
    .readData  (readData)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  function automatic word_t fillWord(input int idx);
    logic [7:0] i8;
    i8 = idx[7:0];
    return {i8 ^ 8'ha5, i8, ~i8, i8 + 8'h3c};
  endfunction

  function automatic int randomBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // instruction encoders
  function automatic word_t rType(input logic [5:0] fn, input regIdx_t s, input regIdx_t t,
                                  input regIdx_t d, input logic [4:0] sh);
    return {`OP_SPECIAL, s, t, d, sh, fn};
  endfunction

  function automatic word_t iType(input logic [5:0] op, input regIdx_t s, input regIdx_t t,
                                  input logic [15:0] imm);
    return {op, s, t, imm};
  endfunction

  function automatic word_t jType(input logic [5:0] op, input int wordIdx);
    return {op, 26'(wordIdx)};
  endfunction

  function automatic word_t randomAlu(input int sel, input regIdx_t s, input regIdx_t t,
                                      input regIdx_t d, input logic [4:0] sh,
                                      input logic [15:0] imm);
    case (sel)
      0:       return rType(`FN_ADDU, s, t, d, 5'd0);
      1:       return rType(`FN_SUBU, s, t, d, 5'd0);
      2:       return rType(`FN_AND, s, t, d, 5'd0);
      3:       return rType(`FN_OR, s, t, d, 5'd0);
      4:       return rType(`FN_XOR, s, t, d, 5'd0);
      5:       return rType(`FN_NOR, s, t, d, 5'd0);
      6:       return rType(`FN_SLT, s, t, d, 5'd0);
      7:       return rType(`FN_SLTU, s, t, d, 5'd0);
      8:       return rType(`FN_SLL, 5'd0, t, d, sh);
      9:       return rType(`FN_SRL, 5'd0, t, d, sh);
      10:      return rType(`FN_SRA, 5'd0, t, d, sh);
      11:      return iType(`OP_ADDIU, s, d, imm);
      12:      return iType(`OP_SLTI, s, d, imm);
      13:      return iType(`OP_ANDI, s, d, imm);
      14:      return iType(`OP_ORI, s, d, imm);
      15:      return iType(`OP_XORI, s, d, imm);
      default: return iType(`OP_LUI, 5'd0, d, imm);
    endcase
  endfunction

  task automatic emitInstr(input word_t w);
    prog[progLen] = w;
    progLen++;
  endtask

  task automatic loadConst(input regIdx_t r, input word_t v);
    emitInstr(iType(`OP_LUI, 5'd0, r, v[31:16]));
    emitInstr(iType(`OP_ORI, r, r, v[15:0]));
  endtask

  // results go to consecutive words above address 0x100 held in r1
  task automatic storeResult(input regIdx_t r);
    emitInstr(iType(`OP_SW, 5'd1, r, slot));
    slot = (slot + 16'd4) & 16'h01fc;
  endtask

  // one word at 0x40 (r2) read back at every lane
  task automatic loadStoreRound();
    int off;
    loadConst(5'd9, $random(seed));
    emitInstr(iType(`OP_SW, 5'd2, 5'd9, 16'h0000));
    for (off = 0; off < 4; off++) begin
      emitInstr(iType(`OP_LB, 5'd2, 5'd10, 16'(off)));
      storeResult(5'd10);
      emitInstr(iType(`OP_LBU, 5'd2, 5'd10, 16'(off)));
      storeResult(5'd10);
      if (off % 2 == 0) begin
        emitInstr(iType(`OP_LH, 5'd2, 5'd10, 16'(off)));
        storeResult(5'd10);
        emitInstr(iType(`OP_LHU, 5'd2, 5'd10, 16'(off)));
        storeResult(5'd10);
      end
    end
    emitInstr(iType(`OP_LW, 5'd2, 5'd10, 16'h0000));
    storeResult(5'd10);
  endtask

  // skipped slots bump r6, so a wrong outcome also shows in its final value
  task automatic branchCase(input logic [5:0] op, input regIdx_t s, input regIdx_t t);
    int skip;
    skip = 1 + randomBelow(2);
    emitInstr(iType(op, s, t, 16'(skip)));
    repeat (skip) emitInstr(iType(`OP_ADDIU, 5'd6, 5'd6, 16'd1));
  endtask

  // executes one instruction on the model and sets the expected bus activity
  function automatic void modelStep(input word_t ins);
    logic [5:0] op;
    logic [5:0] fn;
    regIdx_t    dst;
    word_t      a;
    word_t      b;
    word_t      se;
    word_t      ze;
    word_t      res;
    word_t      ea;
    word_t      lane;
    word_t      halfLane;
    word_t      pc4;
    logic       wr;
    op  = ins[31:26];
    fn  = ins[5:0];
    a   = modelRegs[ins[25:21]];
    b   = modelRegs[ins[20:16]];
    se  = {{16{ins[15]}}, ins[15:0]};
    ze  = {16'h0000, ins[15:0]};
    ea  = a + se;
    pc4 = modelPc + `PC_INCR;
    dst = ins[20:16];
    res = '0;
    wr  = 1'b0;
    expStore = 1'b0;
    expLoad  = 1'b0;
    expAddr  = ea;
    expData  = b;
    // lowest address holds the most significant byte or half
    lane     = modelMem[ea[9:2]] >> (8 * (3 - ea[1:0]));
    halfLane = modelMem[ea[9:2]] >> (16 * (1 - ea[1]));
    modelPc  = pc4;
    case (op)
      `OP_SPECIAL: begin
        dst = ins[15:11];
        wr  = 1'b1;
        case (fn)
          `FN_ADDU: res = a + b;
          `FN_SUBU: res = a - b;
          `FN_AND:  res = a & b;
          `FN_OR:   res = a | b;
          `FN_XOR:  res = a ^ b;
          `FN_NOR:  res = ~(a | b);
          `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
          `FN_SLL:  res = b << ins[10:6];
          `FN_SRL:  res = b >> ins[10:6];
          `FN_SRA:  res = $signed(b) >>> ins[10:6];
          `FN_JR: begin
            wr      = 1'b0;
            modelPc = a;
          end
          default:  wr = 1'b0;
        endcase
      end
      `OP_ADDIU: {wr, res} = {1'b1, a + se};
      `OP_SLTI:  {wr, res} = {1'b1, ($signed(a) < $signed(se)) ? 32'd1 : 32'd0};
      `OP_ANDI:  {wr, res} = {1'b1, a & ze};
      `OP_ORI:   {wr, res} = {1'b1, a | ze};
      `OP_XORI:  {wr, res} = {1'b1, a ^ ze};
      `OP_LUI:   {wr, res} = {1'b1, ins[15:0], 16'h0000};
      `OP_LW:    {wr, expLoad, res} = {2'b11, modelMem[ea[9:2]]};
      `OP_LB:    {wr, expLoad, res} = {2'b11, {24{lane[7]}}, lane[7:0]};
      `OP_LBU:   {wr, expLoad, res} = {2'b11, 24'h000000, lane[7:0]};
      `OP_LH:    {wr, expLoad, res} = {2'b11, {16{halfLane[15]}}, halfLane[15:0]};
      `OP_LHU:   {wr, expLoad, res} = {2'b11, 16'h0000, halfLane[15:0]};
      `OP_SW: begin
        expStore = 1'b1;
        modelMem[ea[9:2]] = b;
      end
      `OP_BEQ:  if (a == b) modelPc = pc4 + {se[29:0], 2'b00};
      `OP_BNE:  if (a != b) modelPc = pc4 + {se[29:0], 2'b00};
      `OP_BLEZ: if ($signed(a) <= 0) modelPc = pc4 + {se[29:0], 2'b00};
      `OP_BGTZ: if ($signed(a) > 0) modelPc = pc4 + {se[29:0], 2'b00};
      `OP_J:    modelPc = {pc4[31:28], ins[25:0], 2'b00};
      `OP_JAL: begin
        modelPc = {pc4[31:28], ins[25:0], 2'b00};
        {wr, dst, res} = {1'b1, 5'd31, pc4};
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      modelRegs[dst] = res;
    end
  endfunction

  // sample mid-cycle while everything is settled
  initial begin : compareProc
    word_t prevPc;
    int    step;
    step = 0;
    forever begin
      @(negedge CLK);
      if (!reset && !done) begin
        checkValue($sformatf("pc at step %0d", step), modelPc, pc);
        prevPc = modelPc;
        modelStep(prog[modelPc[11:2]]);
        checkValue($sformatf("memRead at step %0d", step), {31'b0, expLoad}, {31'b0, memRead});
        checkValue($sformatf("memWrite at step %0d", step), {31'b0, expStore},
                   {31'b0, memWrite});
        if (expStore) begin
          checkValue($sformatf("store address at step %0d", step), expAddr, aluOut);
          checkValue($sformatf("store data at step %0d", step), expData, writeData);
        end
        // the final branch loops on itself
        if (modelPc == prevPc) begin
          done = 1'b1;
        end
        step++;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    // every instruction runs at most once, plus reset and margin
    #((progLen + 5 + 40) * 10);
    $display("watchdog expired before the program reached its final loop");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin : mainProc
    int      i;
    int      base;
    regIdx_t s;
    regIdx_t t;
    regIdx_t d;
    reset      = 1'b1;
    loaded     = 1'b0;
    done       = 1'b0;
    seed       = 32'ha4ce_0ab4;
    progLen    = 0;
    slot       = 16'h0000;
    modelPc    = `PC_INIT;
    // unused rom words jump to themselves
    for (i = 0; i < 1024; i++) begin
      prog[i] = {`OP_J, 16'h0000, 10'(i)};
    end
    for (i = 0; i < 256; i++) begin
      u_mem.ram[i] = fillWord(i);
      modelMem[i]  = fillWord(i);
    end
    for (i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end

    // r1 result area, r2 load area, r4 positive, r5 negative
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd1, 16'h0100));
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd2, 16'h0040));
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd4, 16'd5));
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd5, 16'hfffd));
    for (i = 8; i < 16; i++) begin
      loadConst(regIdx_t'(i), $random(seed));
    end

    // random alu ops with some aimed at r0
    repeat (40) begin
      s = regIdx_t'(8 + randomBelow(8));
      t = regIdx_t'(8 + randomBelow(8));
      d = (randomBelow(8) == 0) ? 5'd0 : regIdx_t'(8 + randomBelow(8));
      emitInstr(randomAlu(randomBelow(17), s, t, d, 5'(randomBelow(32)),
                          16'(randomBelow(65536))));
      storeResult(d);
    end

    repeat (3) loadStoreRound();

    emitInstr(iType(`OP_ADDIU, 5'd8, 5'd0, 16'(randomBelow(65536))));
    emitInstr(rType(`FN_ADDU, 5'd8, 5'd9, 5'd0, 5'd0));
    storeResult(5'd0);

    // taken and not taken for each branch kind
    branchCase(`OP_BEQ, 5'd4, 5'd4);
    branchCase(`OP_BEQ, 5'd4, 5'd5);
    branchCase(`OP_BNE, 5'd4, 5'd5);
    branchCase(`OP_BNE, 5'd4, 5'd4);
    branchCase(`OP_BLEZ, 5'd5, 5'd0);
    branchCase(`OP_BLEZ, 5'd0, 5'd0);
    branchCase(`OP_BLEZ, 5'd4, 5'd0);
    branchCase(`OP_BGTZ, 5'd4, 5'd0);
    branchCase(`OP_BGTZ, 5'd5, 5'd0);
    branchCase(`OP_BGTZ, 5'd0, 5'd0);
    storeResult(5'd6);

    // call and return, then the return address is stored
    base = progLen;
    emitInstr(jType(`OP_JAL, base + 3));
    storeResult(5'd31);
    emitInstr(jType(`OP_J, base + 6));
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd7, 16'(randomBelow(65536))));
    storeResult(5'd7);
    emitInstr(rType(`FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));

    // register jump over two slots
    base = progLen;
    emitInstr(iType(`OP_ADDIU, 5'd0, 5'd3, 16'((base + 4) * 4)));
    emitInstr(rType(`FN_JR, 5'd3, 5'd0, 5'd0, 5'd0));
    emitInstr(iType(`OP_ADDIU, 5'd6, 5'd6, 16'd1));
    emitInstr(iType(`OP_ADDIU, 5'd6, 5'd6, 16'd1));
    storeResult(5'd6);

    emitInstr(iType(`OP_BEQ, 5'd0, 5'd0, 16'hffff));

    for (i = 0; i < 1024; i++) begin
      u_mem.rom[i] = prog[i];
    end
    loaded = 1'b1;

    repeat (5) @(posedge CLK);
    #1 reset = 1'b0;

    wait (done);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: testbench/tbMemory.sv
// word-addressed models with 1024 ROM words and 256 RAM words, and upper address bits are ignored
`timescale 1ns/1ps

module tbMemory import core_pkg::*; (
  input  logic  CLK,
  input  word_t pc,
  output word_t instr,
  input  word_t addr,
  input  word_t writeData,
  input  logic  memWrite,
  output word_t readData
);

  // contents are loaded by the testbench before reset ends
  word_t rom [1024];
  word_t ram [256];

  // both reads answer in the same cycle
  assign instr    = rom[pc[11:2]];
  assign readData = ram[addr[9:2]];

  always @(posedge CLK) begin
    if (memWrite) begin
      ram[addr[9:2]] <= writeData;
    end
  end

endmodule
